//--- design/mipsPkg.sv
package mipsPkg;

	//////////////////////////////////////////////////
	// Widths and fixed addresses
	//////////////////////////////////////////////////

	localparam int dataW = 32;
	localparam int regAddrW = 5;

	localparam logic [dataW-1:0] resetPc = 32'h0000_3000;
	localparam logic [regAddrW-1:0] linkReg = 5'd31;

	// Forwarding sources, fwdReg is the file or the stage register
	localparam logic [1:0] fwdReg = 2'd0;
	localparam logic [1:0] fwdEx = 2'd1;
	localparam logic [1:0] fwdMem = 2'd2;
	localparam logic [1:0] fwdWb = 2'd3;

	// Use time of an operand that is never read
	localparam logic [1:0] tUseNone = 2'd3;

	//////////////////////////////////////////////////
	// Enums
	//////////////////////////////////////////////////

	typedef enum logic [7:0] {
		kindNop,
		kindAddu, kindSubu, kindAnd, kindOr, kindSlt, kindSltu,
		kindAddiu, kindAndi, kindOri, kindLui,
		kindLw, kindLh, kindLb,
		kindSw, kindSh, kindSb,
		kindBeq, kindBne, kindJal, kindJr
	} instrKind_e;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluSltu, aluLui
	} aluOp_e;

	typedef enum logic [1:0] {
		memNone, memByte, memHalf, memWord
	} memSize_e;

	//////////////////////////////////////////////////
	// Pipeline bundles
	//////////////////////////////////////////////////

	typedef struct packed {
		instrKind_e kind;
		aluOp_e aluOp;
		logic aluUsesImm;
		memSize_e memSize;
		logic memWrite;
		logic memRead;
		logic regWrite;
		logic [regAddrW-1:0] destReg;
		logic [1:0] tUseRs;
		logic [1:0] tUseRt;
		logic [1:0] tNew;
	} ctrl_t;

	typedef struct packed {
		logic [dataW-1:0] pc;
		ctrl_t ctrl;
		logic [regAddrW-1:0] rs;
		logic [regAddrW-1:0] rt;
		logic [dataW-1:0] rsVal;
		logic [dataW-1:0] rtVal;
		logic [dataW-1:0] extImm;
	} deToEx_t;

	typedef struct packed {
		logic [dataW-1:0] pc;
		ctrl_t ctrl;
		logic [regAddrW-1:0] rt;
		logic [dataW-1:0] result;
		logic [dataW-1:0] storeVal;
	} exToMem_t;

	typedef struct packed {
		logic [dataW-1:0] pc;
		ctrl_t ctrl;
		logic [dataW-1:0] result;
	} memToWb_t;

	// Control of an empty slot
	localparam ctrl_t bubbleCtrl = '{
		kind:       kindNop,
		aluOp:      aluAdd,
		aluUsesImm: 1'b0,
		memSize:    memNone,
		memWrite:   1'b0,
		memRead:    1'b0,
		regWrite:   1'b0,
		destReg:    '0,
		tUseRs:     tUseNone,
		tUseRt:     tUseNone,
		tNew:       2'd0
	};

endpackage

//--- design/controlDecoder.sv
`timescale 1ns/1ns

module controlDecoder (
	input  logic [mipsPkg::dataW-1:0] instr,
	input  logic [mipsPkg::dataW-1:0] pc,
	output mipsPkg::ctrl_t            ctrl,
	output logic [mipsPkg::dataW-1:0] extImm,
	output logic [mipsPkg::dataW-1:0] branchTarget
);

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [mipsPkg::regAddrW-1:0] rt;
	logic [mipsPkg::regAddrW-1:0] rd;
	logic [mipsPkg::regAddrW-1:0] dest;
	logic [15:0] imm;
	logic [mipsPkg::dataW-1:0] pcPlus4;
	mipsPkg::instrKind_e kind;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign imm = instr[15:0];
	assign pcPlus4 = pc + 32'd4;

	// Opcode and function field classification
	always_comb begin
		kind = mipsPkg::kindNop;
		case (opcode)
			6'b000000: begin
				case (funct)
					6'b100001: kind = mipsPkg::kindAddu;
					6'b100011: kind = mipsPkg::kindSubu;
					6'b100100: kind = mipsPkg::kindAnd;
					6'b100101: kind = mipsPkg::kindOr;
					6'b101010: kind = mipsPkg::kindSlt;
					6'b101011: kind = mipsPkg::kindSltu;
					6'b001000: kind = mipsPkg::kindJr;
					default: kind = mipsPkg::kindNop;
				endcase
			end
			6'b001001: kind = mipsPkg::kindAddiu;
			6'b001100: kind = mipsPkg::kindAndi;
			6'b001101: kind = mipsPkg::kindOri;
			6'b001111: kind = mipsPkg::kindLui;
			6'b100011: kind = mipsPkg::kindLw;
			6'b100001: kind = mipsPkg::kindLh;
			6'b100000: kind = mipsPkg::kindLb;
			6'b101011: kind = mipsPkg::kindSw;
			6'b101001: kind = mipsPkg::kindSh;
			6'b101000: kind = mipsPkg::kindSb;
			6'b000100: kind = mipsPkg::kindBeq;
			6'b000101: kind = mipsPkg::kindBne;
			6'b000011: kind = mipsPkg::kindJal;
			default: kind = mipsPkg::kindNop;
		endcase
	end

	always_comb begin
		ctrl = mipsPkg::bubbleCtrl;
		ctrl.kind = kind;
		dest = rt;
		case (kind)
			mipsPkg::kindAddu, mipsPkg::kindSubu, mipsPkg::kindAnd,
			mipsPkg::kindOr, mipsPkg::kindSlt, mipsPkg::kindSltu: begin
				ctrl.regWrite = 1'b1;
				ctrl.tUseRs = 2'd1;
				ctrl.tUseRt = 2'd1;
				ctrl.tNew = 2'd1;
				dest = rd;
			end
			mipsPkg::kindAddiu, mipsPkg::kindAndi, mipsPkg::kindOri, mipsPkg::kindLui: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluUsesImm = 1'b1;
				ctrl.tUseRs = 2'd1;
				ctrl.tNew = 2'd1;
			end
			mipsPkg::kindLw, mipsPkg::kindLh, mipsPkg::kindLb: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.aluUsesImm = 1'b1;
				ctrl.tUseRs = 2'd1;
				ctrl.tNew = 2'd2;
			end
			mipsPkg::kindSw, mipsPkg::kindSh, mipsPkg::kindSb: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluUsesImm = 1'b1;
				ctrl.tUseRs = 2'd1;
				// Store data is needed only in the memory stage
				ctrl.tUseRt = 2'd2;
			end
			mipsPkg::kindBeq, mipsPkg::kindBne: begin
				ctrl.tUseRs = 2'd0;
				ctrl.tUseRt = 2'd0;
			end
			mipsPkg::kindJal: begin
				ctrl.regWrite = 1'b1;
				dest = mipsPkg::linkReg;
			end
			mipsPkg::kindJr: ctrl.tUseRs = 2'd0;
			default: ctrl.tNew = 2'd0;
		endcase

		case (kind)
			mipsPkg::kindSubu: ctrl.aluOp = mipsPkg::aluSub;
			mipsPkg::kindAnd, mipsPkg::kindAndi: ctrl.aluOp = mipsPkg::aluAnd;
			mipsPkg::kindOr, mipsPkg::kindOri: ctrl.aluOp = mipsPkg::aluOr;
			mipsPkg::kindSlt: ctrl.aluOp = mipsPkg::aluSlt;
			mipsPkg::kindSltu: ctrl.aluOp = mipsPkg::aluSltu;
			mipsPkg::kindLui: ctrl.aluOp = mipsPkg::aluLui;
			default: ctrl.aluOp = mipsPkg::aluAdd;
		endcase

		case (kind)
			mipsPkg::kindLw, mipsPkg::kindSw: ctrl.memSize = mipsPkg::memWord;
			mipsPkg::kindLh, mipsPkg::kindSh: ctrl.memSize = mipsPkg::memHalf;
			mipsPkg::kindLb, mipsPkg::kindSb: ctrl.memSize = mipsPkg::memByte;
			default: ctrl.memSize = mipsPkg::memNone;
		endcase

		ctrl.destReg = dest;
		// Register 0 is never written
		if (dest == '0) begin
			ctrl.regWrite = 1'b0;
		end
	end

	always_comb begin
		case (kind)
			mipsPkg::kindAndi, mipsPkg::kindOri: extImm = {16'h0000, imm};
			mipsPkg::kindLui: extImm = {imm, 16'h0000};
			default: extImm = {{16{imm[15]}}, imm};
		endcase
	end

	assign branchTarget = (kind == mipsPkg::kindJal) ?
		{pcPlus4[31:28], instr[25:0], 2'b00} :
		pcPlus4 + {{14{imm[15]}}, imm, 2'b00};

endmodule

//--- design/regFile.sv
`timescale 1ns/1ns

module regFile (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         we,
	input  logic [mipsPkg::regAddrW-1:0] waddr,
	input  logic [mipsPkg::dataW-1:0]    wdata,
	input  logic [mipsPkg::regAddrW-1:0] raddrA,
	input  logic [mipsPkg::regAddrW-1:0] raddrB,
	output logic [mipsPkg::dataW-1:0]    rdataA,
	output logic [mipsPkg::dataW-1:0]    rdataB
);

	logic [mipsPkg::dataW-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// Zero register, then bypass of the write in flight
	function automatic logic [mipsPkg::dataW-1:0] readPort(logic [mipsPkg::regAddrW-1:0] addr);
		if (addr == '0) begin
			return '0;
		end
		return (we && waddr == addr) ? wdata : regs[addr];
	endfunction

	always_comb begin
		rdataA = readPort(raddrA);
		rdataB = readPort(raddrB);
	end

endmodule

//--- design/hazardUnit.sv
`timescale 1ns/1ns

module hazardUnit (
	input  logic [mipsPkg::regAddrW-1:0] decRs,
	input  logic [mipsPkg::regAddrW-1:0] decRt,
	input  logic [1:0]                   decUseRs,
	input  logic [1:0]                   decUseRt,
	input  mipsPkg::ctrl_t               exCtrl,
	input  mipsPkg::ctrl_t               memCtrl,
	input  mipsPkg::ctrl_t               wbCtrl,
	input  logic [mipsPkg::regAddrW-1:0] exRs,
	input  logic [mipsPkg::regAddrW-1:0] exRt,
	output logic                         stall,
	output logic [1:0]                   fwdDecRs,
	output logic [1:0]                   fwdDecRt,
	output logic [1:0]                   fwdExRs,
	output logic [1:0]                   fwdExRt
);

	function automatic logic writes(mipsPkg::ctrl_t c, logic [mipsPkg::regAddrW-1:0] r);
		return c.regWrite && (r != '0) && (c.destReg == r);
	endfunction

	// Operand needed before a later stage can provide it
	function automatic logic mustWait(logic [mipsPkg::regAddrW-1:0] r, logic [1:0] tUse);
		return (writes(exCtrl, r) && tUse < exCtrl.tNew) ||
			(writes(memCtrl, r) && tUse < memCtrl.tNew);
	endfunction

	// Youngest producer wins, an unready one is caught later
	function automatic logic [1:0] decSelect(logic [mipsPkg::regAddrW-1:0] r);
		if (writes(exCtrl, r)) begin
			return (exCtrl.tNew == 2'd0) ? mipsPkg::fwdEx : mipsPkg::fwdReg;
		end
		if (writes(memCtrl, r)) begin
			return (memCtrl.tNew == 2'd0) ? mipsPkg::fwdMem : mipsPkg::fwdReg;
		end
		return writes(wbCtrl, r) ? mipsPkg::fwdWb : mipsPkg::fwdReg;
	endfunction

	function automatic logic [1:0] exSelect(logic [mipsPkg::regAddrW-1:0] r);
		if (writes(memCtrl, r)) begin
			return (memCtrl.tNew == 2'd0) ? mipsPkg::fwdMem : mipsPkg::fwdReg;
		end
		return writes(wbCtrl, r) ? mipsPkg::fwdWb : mipsPkg::fwdReg;
	endfunction

	always_comb begin
		stall = mustWait(decRs, decUseRs) || mustWait(decRt, decUseRt);
		fwdDecRs = decSelect(decRs);
		fwdDecRt = decSelect(decRt);
		fwdExRs = exSelect(exRs);
		fwdExRt = exSelect(exRt);
	end

endmodule

//--- design/alu.sv
`timescale 1ns/1ns

module alu (
	input  mipsPkg::aluOp_e           op,
	input  logic [mipsPkg::dataW-1:0] a,
	input  logic [mipsPkg::dataW-1:0] b,
	output logic [mipsPkg::dataW-1:0] result
);

	logic signedLess;
	logic unsignedLess;

	assign signedLess = $signed(a) < $signed(b);
	assign unsignedLess = a < b;

	always_comb begin
		case (op)
			mipsPkg::aluAdd: result = a + b;
			mipsPkg::aluSub: result = a - b;
			mipsPkg::aluAnd: result = a & b;
			mipsPkg::aluOr: result = a | b;
			mipsPkg::aluSlt: result = {{(mipsPkg::dataW-1){1'b0}}, signedLess};
			mipsPkg::aluSltu: result = {{(mipsPkg::dataW-1){1'b0}}, unsignedLess};
			// Immediate arrives already shifted into the upper half
			mipsPkg::aluLui: result = b;
			default: result = a + b;
		endcase
	end

endmodule

//--- design/memAlign.sv
`timescale 1ns/1ns

module memAlign (
	input  mipsPkg::memSize_e         size,
	input  logic                      isStore,
	input  logic [1:0]                addr,
	input  logic [mipsPkg::dataW-1:0] storeVal,
	input  logic [mipsPkg::dataW-1:0] rawRead,
	output logic [mipsPkg::dataW-1:0] wdata,
	output logic [3:0]                byteen,
	output logic [mipsPkg::dataW-1:0] loadVal
);

	logic [7:0] byteLane;
	logic [15:0] halfLane;

	//////////////////////////////////////////////////
	// Store side
	//////////////////////////////////////////////////

	always_comb begin
		wdata = storeVal;
		byteen = 4'b0000;
		case (size)
			mipsPkg::memByte: begin
				wdata = {4{storeVal[7:0]}};
				byteen = 4'b0001 << addr;
			end
			mipsPkg::memHalf: begin
				wdata = {2{storeVal[15:0]}};
				byteen = addr[1] ? 4'b1100 : 4'b0011;
			end
			mipsPkg::memWord: byteen = 4'b1111;
			default: byteen = 4'b0000;
		endcase
		if (!isStore) begin
			byteen = 4'b0000;
		end
	end

	//////////////////////////////////////////////////
	// Load side
	//////////////////////////////////////////////////

	assign byteLane = rawRead[8*addr +: 8];
	assign halfLane = addr[1] ? rawRead[31:16] : rawRead[15:0];

	always_comb begin
		case (size)
			mipsPkg::memByte: loadVal = {{24{byteLane[7]}}, byteLane};
			mipsPkg::memHalf: loadVal = {{16{halfLane[15]}}, halfLane};
			default: loadVal = rawRead;
		endcase
	end

endmodule

//--- design/pipelineCpu.sv
`timescale 1ns/1ns

module pipelineCpu (
	input  logic                         clk,
	input  logic                         reset,
	output logic [mipsPkg::dataW-1:0]    instAddr,
	input  logic [mipsPkg::dataW-1:0]    instRdata,
	output logic [mipsPkg::dataW-1:0]    dataAddr,
	output logic [mipsPkg::dataW-1:0]    dataWdata,
	output logic [3:0]                   dataByteen,
	input  logic [mipsPkg::dataW-1:0]    dataRdata,
	output logic                         grfWe,
	output logic [mipsPkg::regAddrW-1:0] grfAddr,
	output logic [mipsPkg::dataW-1:0]    grfWdata,
	output logic [mipsPkg::dataW-1:0]    grfPc
);

	typedef struct packed {
		logic [mipsPkg::dataW-1:0] pc;
		logic [mipsPkg::dataW-1:0] instr;
	} fetchReg_t;

	logic [mipsPkg::dataW-1:0] pc;
	logic [mipsPkg::dataW-1:0] nextPc;
	fetchReg_t ifToDe;
	mipsPkg::deToEx_t deToEx;
	mipsPkg::exToMem_t exToMem;
	mipsPkg::memToWb_t memToWb;

	mipsPkg::ctrl_t decCtrl;
	logic [mipsPkg::regAddrW-1:0] decRs;
	logic [mipsPkg::regAddrW-1:0] decRt;
	logic [mipsPkg::dataW-1:0] decExtImm;
	logic [mipsPkg::dataW-1:0] decTarget;
	logic [mipsPkg::dataW-1:0] fileRs;
	logic [mipsPkg::dataW-1:0] fileRt;
	logic [mipsPkg::dataW-1:0] decRsVal;
	logic [mipsPkg::dataW-1:0] decRtVal;
	logic stall;
	logic [1:0] fwdDecRs;
	logic [1:0] fwdDecRt;
	logic [1:0] fwdExRs;
	logic [1:0] fwdExRt;

	logic [mipsPkg::dataW-1:0] exRsVal;
	logic [mipsPkg::dataW-1:0] exRtVal;
	logic [mipsPkg::dataW-1:0] aluB;
	logic [mipsPkg::dataW-1:0] aluResult;
	logic [mipsPkg::dataW-1:0] exResult;

	logic [mipsPkg::dataW-1:0] memStoreVal;
	logic [mipsPkg::dataW-1:0] memLoadVal;

	function automatic logic [1:0] ageTNew(logic [1:0] t);
		return (t == 2'd0) ? 2'd0 : t - 2'd1;
	endfunction

	// Shared operand mux for decode and execute
	function automatic logic [mipsPkg::dataW-1:0] pickOperand(
		logic [1:0] sel,
		logic [mipsPkg::dataW-1:0] ownVal
	);
		case (sel)
			mipsPkg::fwdEx: return exResult;
			mipsPkg::fwdMem: return exToMem.result;
			mipsPkg::fwdWb: return memToWb.result;
			default: return ownVal;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Fetch
	//////////////////////////////////////////////////

	assign instAddr = pc;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= mipsPkg::resetPc;
		end else if (!stall) begin
			pc <= nextPc;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ifToDe.instr <= '0;
		end else if (!stall) begin
			ifToDe.pc <= pc;
			ifToDe.instr <= instRdata;
		end
	end

	//////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////

	assign decRs = ifToDe.instr[25:21];
	assign decRt = ifToDe.instr[20:16];

	controlDecoder decoder_i (
		.instr(ifToDe.instr),
		.pc(ifToDe.pc),
		.ctrl(decCtrl),
		.extImm(decExtImm),
		.branchTarget(decTarget)
	);

	regFile regFile_i (
		.clk(clk),
		.reset(reset),
		.we(grfWe),
		.waddr(grfAddr),
		.wdata(grfWdata),
		.raddrA(decRs),
		.raddrB(decRt),
		.rdataA(fileRs),
		.rdataB(fileRt)
	);

	hazardUnit hazard_i (
		.decRs(decRs),
		.decRt(decRt),
		.decUseRs(decCtrl.tUseRs),
		.decUseRt(decCtrl.tUseRt),
		.exCtrl(deToEx.ctrl),
		.memCtrl(exToMem.ctrl),
		.wbCtrl(memToWb.ctrl),
		.exRs(deToEx.rs),
		.exRt(deToEx.rt),
		.stall(stall),
		.fwdDecRs(fwdDecRs),
		.fwdDecRt(fwdDecRt),
		.fwdExRs(fwdExRs),
		.fwdExRt(fwdExRt)
	);

	always_comb begin
		decRsVal = pickOperand(fwdDecRs, fileRs);
		decRtVal = pickOperand(fwdDecRt, fileRt);
	end

	// Branches resolve here, the delay slot is already in fetch
	always_comb begin
		nextPc = pc + 32'd4;
		case (decCtrl.kind)
			mipsPkg::kindBeq: begin
				if (decRsVal == decRtVal) begin
					nextPc = decTarget;
				end
			end
			mipsPkg::kindBne: begin
				if (decRsVal != decRtVal) begin
					nextPc = decTarget;
				end
			end
			mipsPkg::kindJal: nextPc = decTarget;
			mipsPkg::kindJr: nextPc = decRsVal;
			default: nextPc = pc + 32'd4;
		endcase
	end

	always_ff @(posedge clk) begin
		deToEx.pc <= ifToDe.pc;
		deToEx.rs <= decRs;
		deToEx.rt <= decRt;
		deToEx.rsVal <= decRsVal;
		deToEx.rtVal <= decRtVal;
		deToEx.extImm <= decExtImm;
		if (reset || stall) begin
			deToEx.ctrl <= mipsPkg::bubbleCtrl;
		end else begin
			deToEx.ctrl <= decCtrl;
		end
	end

	//////////////////////////////////////////////////
	// Execute
	//////////////////////////////////////////////////

	always_comb begin
		exRsVal = pickOperand(fwdExRs, deToEx.rsVal);
		exRtVal = pickOperand(fwdExRt, deToEx.rtVal);
		aluB = deToEx.ctrl.aluUsesImm ? deToEx.extImm : exRtVal;
	end

	alu alu_i (
		.op(deToEx.ctrl.aluOp),
		.a(exRsVal),
		.b(aluB),
		.result(aluResult)
	);

	assign exResult = (deToEx.ctrl.kind == mipsPkg::kindJal) ? deToEx.pc + 32'd8 : aluResult;

	always_ff @(posedge clk) begin
		exToMem.pc <= deToEx.pc;
		exToMem.rt <= deToEx.rt;
		exToMem.result <= exResult;
		exToMem.storeVal <= exRtVal;
		if (reset) begin
			exToMem.ctrl <= mipsPkg::bubbleCtrl;
		end else begin
			exToMem.ctrl <= deToEx.ctrl;
			exToMem.ctrl.tNew <= ageTNew(deToEx.ctrl.tNew);
		end
	end

	//////////////////////////////////////////////////
	// Memory and writeback
	//////////////////////////////////////////////////

	// Store data from a load that has just reached writeback
	assign memStoreVal = (memToWb.ctrl.regWrite && memToWb.ctrl.destReg == exToMem.rt) ?
		memToWb.result : exToMem.storeVal;

	assign dataAddr = exToMem.result;

	memAlign memAlign_i (
		.size(exToMem.ctrl.memSize),
		.isStore(exToMem.ctrl.memWrite),
		.addr(exToMem.result[1:0]),
		.storeVal(memStoreVal),
		.rawRead(dataRdata),
		.wdata(dataWdata),
		.byteen(dataByteen),
		.loadVal(memLoadVal)
	);

	always_ff @(posedge clk) begin
		memToWb.pc <= exToMem.pc;
		memToWb.result <= exToMem.ctrl.memRead ? memLoadVal : exToMem.result;
		if (reset) begin
			memToWb.ctrl <= mipsPkg::bubbleCtrl;
		end else begin
			memToWb.ctrl <= exToMem.ctrl;
			memToWb.ctrl.tNew <= ageTNew(exToMem.ctrl.tNew);
		end
	end

	assign grfWe = memToWb.ctrl.regWrite;
	assign grfAddr = memToWb.ctrl.destReg;
	assign grfWdata = memToWb.result;
	assign grfPc = memToWb.pc;

endmodule

//--- verif/pipelineCpu_properties.sv
`timescale 1ns/1ns

module pipelineCpu_properties (
	input logic                         clk,
	input logic                         reset,
	input logic [mipsPkg::dataW-1:0]    instAddr,
	input logic [3:0]                   dataByteen,
	input logic                         grfWe,
	input logic [mipsPkg::regAddrW-1:0] grfAddr,
	input mipsPkg::exToMem_t            exToMem
);

	// Byte enables are set exactly when a store is in the memory stage
	byteenOnlyOnStore: assert property (@(posedge clk) disable iff (reset)
		(dataByteen != 4'b0000) == exToMem.ctrl.memWrite)
		else $error("byte enables do not match the store in the memory stage");

	noWriteToZero: assert property (@(posedge clk) disable iff (reset)
		grfWe |-> (grfAddr != '0))
		else $error("register 0 written at the writeback port");

	fetchAligned: assert property (@(posedge clk) disable iff (reset)
		instAddr[1:0] == 2'b00)
		else $error("fetch address %h not word aligned", instAddr);

	// Pipeline registers are cleared by the first reset edge
	quietInReset: assert property (@(posedge clk)
		(reset && $past(reset)) |-> (!grfWe && dataByteen == 4'b0000))
		else $error("register write or store seen during reset");

endmodule

bind pipelineCpu pipelineCpu_properties props_i (
	.clk(clk),
	.reset(reset),
	.instAddr(instAddr),
	.dataByteen(dataByteen),
	.grfWe(grfWe),
	.grfAddr(grfAddr),
	.exToMem(exToMem)
);

//--- verif/cpuTb.sv
`timescale 1ns/1ns

module cpuTb;

	typedef struct packed {
		logic [31:0] pc;
		logic [4:0]  dest;
		logic [31:0] value;
	} commit_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [3:0]  byteen;
		logic [31:0] wdata;
	} store_t;

	localparam int imemWords = 64;
	localparam int dmemWords = 256;
	localparam int commitTimeout = 40;
	localparam int idleCycles = 20;

	logic        clk;
	logic        reset;
	logic [31:0] instAddr;
	logic [31:0] instRdata;
	logic [31:0] dataAddr;
	logic [31:0] dataWdata;
	logic [3:0]  dataByteen;
	logic [31:0] dataRdata;
	logic        grfWe;
	logic [4:0]  grfAddr;
	logic [31:0] grfWdata;
	logic [31:0] grfPc;

	logic [31:0] imem [imemWords];
	logic [31:0] dmem [dmemWords];
	commit_t expCommits [$];
	store_t expStores [$];
	store_t seenStores [$];
	store_t pendingStore;
	logic [31:0] seedVal;
	int checks;
	int errors;
	int timeouts;

	pipelineCpu dut_i (
		.clk(clk),
		.reset(reset),
		.instAddr(instAddr),
		.instRdata(instRdata),
		.dataAddr(dataAddr),
		.dataWdata(dataWdata),
		.dataByteen(dataByteen),
		.dataRdata(dataRdata),
		.grfWe(grfWe),
		.grfAddr(grfAddr),
		.grfWdata(grfWdata),
		.grfPc(grfPc)
	);

	always #4 clk = ~clk;

	//////////////////////////////////////////////////
	// Instruction encoding and lane helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] rType(logic [5:0] funct, logic [4:0] rs, logic [4:0] rt,
			logic [4:0] rd);
		return {6'h00, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] iType(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
			logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jType(logic [5:0] op, logic [25:0] target);
		return {op, target};
	endfunction

	function automatic logic [31:0] sext8(logic [7:0] b);
		return {{24{b[7]}}, b};
	endfunction

	function automatic logic [31:0] sext16(logic [15:0] h);
		return {{16{h[15]}}, h};
	endfunction

	function automatic logic [31:0] fetchWord(logic [31:0] addr);
		logic [31:0] offset;
		offset = addr - mipsPkg::resetPc;
		if (offset < imemWords * 4) begin
			return imem[offset[7:2]];
		end
		return 32'h0000_0000;
	endfunction

	//////////////////////////////////////////////////
	// Memory models
	//////////////////////////////////////////////////

	// Combinational answers, presented on the falling edge
	always @(negedge clk) begin
		instRdata <= fetchWord(instAddr);
		dataRdata <= dmem[dataAddr[9:2]];
		pendingStore.addr <= dataAddr;
		pendingStore.byteen <= dataByteen;
		pendingStore.wdata <= dataWdata;
		if (dataByteen != 4'b0000) begin
			seenStores.push_back({dataAddr, dataByteen, dataWdata});
		end
	end

	always @(posedge clk) begin
		for (int b = 0; b < 4; b++) begin
			if (pendingStore.byteen[b]) begin
				dmem[pendingStore.addr[9:2]][8*b +: 8] <= pendingStore.wdata[8*b +: 8];
			end
		end
	end

	task automatic fillDataMemory();
		for (int i = 0; i < dmemWords; i++) begin
			dmem[i] = $urandom() ^ seedVal ^ (i << 2);
		end
	endtask

	task automatic loadProgram();
		logic [31:0] prog [$];
		prog.push_back(iType(6'h0f, 5'd0, 5'd1, 16'h8000));
		prog.push_back(iType(6'h0d, 5'd1, 5'd1, 16'h0005));
		prog.push_back(iType(6'h09, 5'd0, 5'd2, 16'h0005));
		prog.push_back(rType(6'h2a, 5'd1, 5'd2, 5'd3));
		prog.push_back(rType(6'h2b, 5'd1, 5'd2, 5'd4));
		prog.push_back(iType(6'h09, 5'd0, 5'd5, 16'hfff8));
		prog.push_back(rType(6'h21, 5'd5, 5'd2, 5'd6));
		prog.push_back(rType(6'h23, 5'd2, 5'd5, 5'd7));
		prog.push_back(rType(6'h24, 5'd6, 5'd7, 5'd8));
		prog.push_back(rType(6'h25, 5'd8, 5'd1, 5'd9));
		prog.push_back(iType(6'h0c, 5'd9, 5'd10, 16'hf00f));
		prog.push_back(rType(6'h23, 5'd2, 5'd7, 5'd11));
		// Loads from the seeded area at 0x100
		prog.push_back(iType(6'h09, 5'd0, 5'd12, 16'h0100));
		prog.push_back(iType(6'h23, 5'd12, 5'd13, 16'h0000));
		prog.push_back(rType(6'h21, 5'd13, 5'd2, 5'd14));
		prog.push_back(iType(6'h21, 5'd12, 5'd15, 16'h0006));
		prog.push_back(iType(6'h20, 5'd12, 5'd16, 16'h0009));
		prog.push_back(iType(6'h20, 5'd12, 5'd17, 16'h000b));
		// Stores to 0x200, then read back
		prog.push_back(iType(6'h09, 5'd0, 5'd18, 16'h0200));
		prog.push_back(iType(6'h2b, 5'd18, 5'd9, 16'h0000));
		prog.push_back(iType(6'h28, 5'd18, 5'd13, 16'h0005));
		prog.push_back(iType(6'h29, 5'd18, 5'd5, 16'h000a));
		prog.push_back(iType(6'h23, 5'd18, 5'd19, 16'h0000));
		prog.push_back(iType(6'h20, 5'd18, 5'd20, 16'h0005));
		prog.push_back(iType(6'h21, 5'd18, 5'd21, 16'h000a));
		prog.push_back(iType(6'h23, 5'd12, 5'd22, 16'h0004));
		prog.push_back(iType(6'h2b, 5'd18, 5'd22, 16'h000c));
		prog.push_back(iType(6'h23, 5'd18, 5'd23, 16'h000c));
		// Branches at 0x3070
		prog.push_back(iType(6'h04, 5'd2, 5'd7, 16'h0002));
		prog.push_back(iType(6'h09, 5'd0, 5'd24, 16'h0001));
		prog.push_back(iType(6'h09, 5'd24, 5'd24, 16'h0001));
		prog.push_back(iType(6'h05, 5'd24, 5'd2, 16'h0002));
		prog.push_back(iType(6'h09, 5'd0, 5'd25, 16'h0007));
		prog.push_back(iType(6'h09, 5'd0, 5'd25, 16'h0063));
		prog.push_back(iType(6'h04, 5'd25, 5'd25, 16'h0002));
		prog.push_back(rType(6'h21, 5'd25, 5'd24, 5'd26));
		prog.push_back(iType(6'h09, 5'd0, 5'd26, 16'h004d));
		prog.push_back(iType(6'h05, 5'd0, 5'd0, 16'h0002));
		prog.push_back(iType(6'h09, 5'd0, 5'd27, 16'h0003));
		// jal to 0x30B0, link read in its delay slot
		prog.push_back(jType(6'h03, 26'h0000c2c));
		prog.push_back(rType(6'h21, 5'd31, 5'd0, 5'd28));
		prog.push_back(iType(6'h09, 5'd0, 5'd29, 16'h0006));
		// Spin here for the rest of the run
		prog.push_back(iType(6'h04, 5'd0, 5'd0, 16'hffff));
		prog.push_back(32'h0000_0000);
		prog.push_back(rType(6'h08, 5'd31, 5'd0, 5'd0));
		prog.push_back(iType(6'h09, 5'd0, 5'd30, 16'h0055));
		for (int i = 0; i < imemWords; i++) begin
			imem[i] = (i < prog.size()) ? prog[i] : 32'h0000_0000;
		end
	endtask

	//////////////////////////////////////////////////
	// Expected commits and stores
	//////////////////////////////////////////////////

	task automatic addCommit(logic [31:0] pc, logic [4:0] dest, logic [31:0] value);
		expCommits.push_back({pc, dest, value});
	endtask

	task automatic addStore(logic [31:0] addr, logic [3:0] byteen, logic [31:0] wdata);
		expStores.push_back({addr, byteen, wdata});
	endtask

	task automatic buildExpected();
		logic [31:0] w100;
		logic [31:0] w104;
		logic [31:0] w108;
		w100 = dmem[8'h40];
		w104 = dmem[8'h41];
		w108 = dmem[8'h42];
		addCommit(32'h3000, 5'd1, 32'h8000_0000);
		addCommit(32'h3004, 5'd1, 32'h8000_0005);
		addCommit(32'h3008, 5'd2, 32'h0000_0005);
		addCommit(32'h300c, 5'd3, 32'h0000_0001);
		addCommit(32'h3010, 5'd4, 32'h0000_0000);
		addCommit(32'h3014, 5'd5, 32'hffff_fff8);
		addCommit(32'h3018, 5'd6, 32'hffff_fffd);
		addCommit(32'h301c, 5'd7, 32'h0000_000d);
		addCommit(32'h3020, 5'd8, 32'h0000_000d);
		addCommit(32'h3024, 5'd9, 32'h8000_000d);
		addCommit(32'h3028, 5'd10, 32'h0000_000d);
		addCommit(32'h302c, 5'd11, 32'hffff_fff8);
		addCommit(32'h3030, 5'd12, 32'h0000_0100);
		addCommit(32'h3034, 5'd13, w100);
		addCommit(32'h3038, 5'd14, w100 + 32'd5);
		addCommit(32'h303c, 5'd15, sext16(w104[31:16]));
		addCommit(32'h3040, 5'd16, sext8(w108[15:8]));
		addCommit(32'h3044, 5'd17, sext8(w108[31:24]));
		addCommit(32'h3048, 5'd18, 32'h0000_0200);
		addCommit(32'h3058, 5'd19, 32'h8000_000d);
		addCommit(32'h305c, 5'd20, sext8(w100[7:0]));
		addCommit(32'h3060, 5'd21, 32'hffff_fff8);
		addCommit(32'h3064, 5'd22, w104);
		addCommit(32'h306c, 5'd23, w104);
		addCommit(32'h3074, 5'd24, 32'h0000_0001);
		addCommit(32'h3078, 5'd24, 32'h0000_0002);
		addCommit(32'h3080, 5'd25, 32'h0000_0007);
		addCommit(32'h308c, 5'd26, 32'h0000_0009);
		addCommit(32'h3098, 5'd27, 32'h0000_0003);
		addCommit(32'h309c, 5'd31, 32'h0000_30a4);
		addCommit(32'h30a0, 5'd28, 32'h0000_30a4);
		addCommit(32'h30b4, 5'd30, 32'h0000_0055);
		addCommit(32'h30a4, 5'd29, 32'h0000_0006);
		addStore(32'h0000_0200, 4'b1111, 32'h8000_000d);
		addStore(32'h0000_0205, 4'b0010, {4{w100[7:0]}});
		addStore(32'h0000_020a, 4'b1100, 32'hfff8_fff8);
		addStore(32'h0000_020c, 4'b1111, w104);
	endtask

	//////////////////////////////////////////////////
	// Checking
	//////////////////////////////////////////////////

	task automatic compareValue(string name, logic [31:0] actual, logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERR %0t %s actual=%h expected=%h", $time, name, actual, expected);
		end
	endtask

	task automatic checkCommits();
		int waited;
		bit found;
		for (int i = 0; i < expCommits.size(); i++) begin
			waited = 0;
			found = 1'b0;
			while (!found && waited < commitTimeout) begin
				@(negedge clk);
				if (grfWe === 1'b1) begin
					found = 1'b1;
				end else begin
					waited++;
				end
			end
			if (!found) begin
				timeouts++;
				$display("Timeout, no register write seen for commit %0d at pc %h",
					i, expCommits[i].pc);
				return;
			end
			compareValue("grfPc", grfPc, expCommits[i].pc);
			compareValue("grfAddr", 32'(grfAddr), 32'(expCommits[i].dest));
			compareValue("grfWdata", grfWdata, expCommits[i].value);
		end
	endtask

	// The program ends in a spin loop with no further writes
	task automatic watchIdle();
		for (int i = 0; i < idleCycles; i++) begin
			@(negedge clk);
			if (grfWe === 1'b1) begin
				errors++;
				$display("Unexpected register write to r%0d from pc %h after the last commit",
					grfAddr, grfPc);
			end
		end
	endtask

	task automatic checkStores();
		int n;
		n = (seenStores.size() < expStores.size()) ? seenStores.size() : expStores.size();
		if (seenStores.size() != expStores.size()) begin
			errors++;
			$display("Saw %0d stores on the data port but expected %0d",
				seenStores.size(), expStores.size());
		end
		for (int i = 0; i < n; i++) begin
			compareValue("dataAddr", seenStores[i].addr, expStores[i].addr);
			compareValue("dataByteen", 32'(seenStores[i].byteen), 32'(expStores[i].byteen));
			compareValue("dataWdata", seenStores[i].wdata, expStores[i].wdata);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		instRdata = 32'h0000_0000;
		dataRdata = 32'h0000_0000;
		pendingStore = '0;
		checks = 0;
		errors = 0;
		timeouts = 0;
		seedVal = $urandom(32'h0eab_3b9f);
		fillDataMemory();
		loadProgram();
		buildExpected();
		repeat (10) @(negedge clk);
		reset = 1'b0;
		checkCommits();
		watchIdle();
		checkStores();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- sim.f
design/mipsPkg.sv
design/controlDecoder.sv
design/regFile.sv
design/hazardUnit.sv
design/alu.sv
design/memAlign.sv
design/pipelineCpu.sv
verif/pipelineCpu_properties.sv
verif/cpuTb.sv

//--- run.sh
#!/bin/sh
# Build and run the pipelined MIPS core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module cpuTb \
	-f sim.f \
	--Mdir obj_dir \
	-o cpuTb_sim

./obj_dir/cpuTb_sim > sim.log 2>&1
cat sim.log

if grep -qx "test passed" sim.log; then
	echo "Simulation result: PASS"
else
	echo "Simulation result: FAIL"
	exit 1
fi
